//--- bench/dcache_tb.sv
// testbench: clock, reset, seeded random traffic, reference model, checks and report
`timescale 1ns/1ps

module dcache_tb
  import dcache_addr_pkg::*;
  import dcache_data_pkg::*;
();

  localparam int NUM_WAYS = 4;
  localparam int RESET_CYCLES = 8;
  localparam int STIM_CYCLES = 3000;
  localparam int DRAIN_CYCLES = 4;
  localparam int RUN_CYCLES = STIM_CYCLES + DRAIN_CYCLES;
  // reset, random traffic and drain, plus slack
  localparam int LIMIT_CYCLES = 3200;
  localparam int NUM_TAGS = 6;

  logic                 clock;
  logic                 reset;
  logic                 rd1_strobe;
  logic [ADDR_BITS-1:0] rd1_addr;
  logic                 rd2_strobe;
  logic [ADDR_BITS-1:0] rd2_addr;
  logic                 wr1_strobe;
  logic [ADDR_BITS-1:0] wr1_addr;
  logic [WORD_BITS-1:0] wr1_data;
  logic                 wr2_strobe;
  logic [ADDR_BITS-1:0] wr2_addr;
  logic [WORD_BITS-1:0] wr2_data;
  logic                 rd1_done;
  logic                 rd1_hit;
  logic [WORD_BITS-1:0] rd1_data;
  logic                 rd2_done;
  logic                 rd2_hit;
  logic [WORD_BITS-1:0] rd2_data;
  logic                 wr1_drop;

  // reference model state
  logic [TAG_BITS-1:0]        m_tag   [NUM_SETS][NUM_WAYS];
  logic [BLOCKS_PER_LINE-1:0] m_valid [NUM_SETS][NUM_WAYS];
  logic [WORD_BITS-1:0]       m_data  [NUM_SETS][NUM_WAYS][BLOCKS_PER_LINE];
  int                         m_ptr   [NUM_SETS];

  // expected outputs, indexed by the cycle they are visible in
  logic                 exp_done [2][RUN_CYCLES+2];
  logic                 exp_hit  [2][RUN_CYCLES+2];
  logic [WORD_BITS-1:0] exp_data [2][RUN_CYCLES+2];
  logic                 exp_drop [RUN_CYCLES+2];

  int error_count = 0;
  int reads_checked = 0;
  int hit_count = 0;
  int miss_count = 0;
  int drop_count = 0;
  int evict_count = 0;

  dcache_top #(
    .NUM_WAYS (NUM_WAYS)
  ) UUT (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [ADDR_BITS-1:0] random_addr();
    dcache_addr_t view;
    view.raw = '0;
    view.fields.tag = TAG_BITS'(37 + 4099 * $urandom_range(0, NUM_TAGS - 1));
    view.fields.set = SET_BITS'($urandom_range(0, NUM_SETS - 1));
    view.fields.block = BLOCK_BITS'($urandom_range(0, BLOCKS_PER_LINE - 1));
    return view.raw;
  endfunction

  // way holding this tag with the block valid, or -1
  function automatic int find_way(input logic [SET_BITS-1:0] line_set,
                                  input logic [BLOCK_BITS-1:0] block,
                                  input logic [TAG_BITS-1:0] tag);
    int found;
    found = -1;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (m_valid[line_set][w][block] && (m_tag[line_set][w] == tag)) begin
        found = w;
      end
    end
    return found;
  endfunction

  task automatic predict_read(input int port, input logic [ADDR_BITS-1:0] addr, input int due);
    dcache_addr_t view;
    int way;
    view.raw = addr;
    way = find_way(view.fields.set, view.fields.block, view.fields.tag);
    exp_done[port][due] = 1'b1;
    exp_hit[port][due] = (way >= 0);
    if (way >= 0) begin
      exp_data[port][due] = m_data[view.fields.set][way][view.fields.block];
      hit_count++;
    end else begin
      exp_data[port][due] = MISS_DATA;
      miss_count++;
    end
  endtask

  // hit updates in place, miss allocates under the round-robin pointer
  task automatic model_write(input logic [ADDR_BITS-1:0] addr, input logic [WORD_BITS-1:0] data);
    dcache_addr_t view;
    int way;
    view.raw = addr;
    way = find_way(view.fields.set, view.fields.block, view.fields.tag);
    if (way < 0) begin
      way = m_ptr[view.fields.set];
      if (m_valid[view.fields.set][way] != '0) begin
        evict_count++;
      end
      m_valid[view.fields.set][way] = '0;
      m_tag[view.fields.set][way] = view.fields.tag;
      m_ptr[view.fields.set] = (way + 1) % NUM_WAYS;
    end
    m_data[view.fields.set][way][view.fields.block] = data;
    m_valid[view.fields.set][way][view.fields.block] = 1'b1;
  endtask

  task automatic drive_cycle(input int c);
    logic                 go_rd1;
    logic                 go_rd2;
    logic                 go_wr1;
    logic                 go_wr2;
    logic [ADDR_BITS-1:0] a_rd1;
    logic [ADDR_BITS-1:0] a_rd2;
    logic [ADDR_BITS-1:0] a_wr1;
    logic [ADDR_BITS-1:0] a_wr2;
    logic [WORD_BITS-1:0] d_wr1;
    logic [WORD_BITS-1:0] d_wr2;
    dcache_addr_t         view1;
    dcache_addr_t         view2;
    go_rd1 = ($urandom_range(0, 1) == 1);
    go_rd2 = ($urandom_range(0, 1) == 1);
    go_wr1 = ($urandom_range(0, 1) == 1);
    go_wr2 = ($urandom_range(0, 1) == 1);
    a_rd1 = random_addr();
    a_rd2 = random_addr();
    a_wr1 = random_addr();
    a_wr2 = random_addr();
    d_wr1 = {$urandom, $urandom};
    d_wr2 = {$urandom, $urandom};
    // reads see only writes strobed in earlier cycles
    if (go_rd1) predict_read(0, a_rd1, c + 2);
    if (go_rd2) predict_read(1, a_rd2, c + 2);
    view1.raw = a_wr1;
    view2.raw = a_wr2;
    if (go_wr1 && go_wr2 && (view1.fields.set == view2.fields.set)) begin
      exp_drop[c + 1] = 1'b1;
      drop_count++;
      model_write(a_wr2, d_wr2);
    end else begin
      if (go_wr1) model_write(a_wr1, d_wr1);
      if (go_wr2) model_write(a_wr2, d_wr2);
    end
    rd1_strobe <= go_rd1;
    rd1_addr   <= a_rd1;
    rd2_strobe <= go_rd2;
    rd2_addr   <= a_rd2;
    wr1_strobe <= go_wr1;
    wr1_addr   <= a_wr1;
    wr1_data   <= d_wr1;
    wr2_strobe <= go_wr2;
    wr2_addr   <= a_wr2;
    wr2_data   <= d_wr2;
  endtask

  task automatic report_mismatch(input string name, input logic [WORD_BITS-1:0] expected,
                                 input logic [WORD_BITS-1:0] actual);
    error_count++;
    $display("mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
  endtask

  task automatic check_port(input string name, input int port, input int c, input logic done,
                            input logic hit, input logic [WORD_BITS-1:0] data);
    if (done !== exp_done[port][c]) report_mismatch({name, "_done"}, exp_done[port][c], done);
    if (hit !== exp_hit[port][c]) report_mismatch({name, "_hit"}, exp_hit[port][c], hit);
    if (exp_done[port][c] && (data !== exp_data[port][c])) begin
      report_mismatch({name, "_data"}, exp_data[port][c], data);
    end
    if (done === 1'b1) reads_checked++;
  endtask

  initial begin
    void'($urandom(45012));
    for (int s = 0; s < NUM_SETS; s++) begin
      m_ptr[s] = 0;
      for (int w = 0; w < NUM_WAYS; w++) m_valid[s][w] = '0;
    end
    for (int c = 0; c < RUN_CYCLES + 2; c++) begin
      exp_done[0][c] = 1'b0;
      exp_done[1][c] = 1'b0;
      exp_hit[0][c] = 1'b0;
      exp_hit[1][c] = 1'b0;
      exp_drop[c] = 1'b0;
    end
    reset = 1'b1;
    rd1_strobe = 1'b0;
    rd1_addr = '0;
    rd2_strobe = 1'b0;
    rd2_addr = '0;
    wr1_strobe = 1'b0;
    wr1_addr = '0;
    wr1_data = '0;
    wr2_strobe = 1'b0;
    wr2_addr = '0;
    wr2_data = '0;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;

    for (int c = 0; c < RUN_CYCLES; c++) begin
      @(posedge clock);
      if (c < STIM_CYCLES) begin
        drive_cycle(c);
      end else begin
        rd1_strobe <= 1'b0;
        rd2_strobe <= 1'b0;
        wr1_strobe <= 1'b0;
        wr2_strobe <= 1'b0;
      end
      // outputs settle after the edge, sample mid cycle
      @(negedge clock);
      check_port("rd1", 0, c, rd1_done, rd1_hit, rd1_data);
      check_port("rd2", 1, c, rd2_done, rd2_hit, rd2_data);
      if (wr1_drop !== exp_drop[c]) report_mismatch("wr1_drop", exp_drop[c], wr1_drop);
    end

    if (drop_count == 0) begin
      error_count++;
      $display("no same-set write pair was generated");
    end
    if (evict_count == 0) begin
      error_count++;
      $display("no write miss evicted a valid line");
    end
    if (hit_count == 0) begin
      error_count++;
      $display("no read was expected to hit");
    end
    $display("errors: %0d, reads checked: %0d, hits: %0d, misses: %0d, drops: %0d, evictions: %0d",
             error_count, reads_checked, hit_count, miss_count, drop_count, evict_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // cycle limit
  initial begin
    int elapsed;
    elapsed = 0;
    while (elapsed < LIMIT_CYCLES) begin
      @(posedge clock);
      elapsed++;
    end
    $display("timeout: run did not finish within %0d cycles, errors so far: %0d",
             LIMIT_CYCLES, error_count);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- dcache_top.f
logic/dcache_addr_pkg.sv
logic/dcache_data_pkg.sv
logic/dcache_request_capture.sv
logic/dcache_way.sv
logic/dcache_victim_select.sv
logic/dcache_read_result.sv
logic/dcache_top.sv
bench/dcache_tb.sv

//--- logic/dcache_addr_pkg.sv
// address geometry constants, address field struct and packed address union
package dcache_addr_pkg;

  // byte address width
  localparam int ADDR_BITS = 32;

  // 64-bit block, four blocks per line
  localparam int BYTE_BITS = 3;
  localparam int BLOCK_BITS = 2;
  localparam int BLOCKS_PER_LINE = 1 << BLOCK_BITS;

  localparam int SET_BITS = 4;
  localparam int NUM_SETS = 1 << SET_BITS;

  // tag takes whatever is left above the set index
  localparam int TAG_BITS = ADDR_BITS - SET_BITS - BLOCK_BITS - BYTE_BITS;

  typedef struct packed {
    logic [TAG_BITS-1:0]   tag;
    logic [SET_BITS-1:0]   set;
    logic [BLOCK_BITS-1:0] block;
    logic [BYTE_BITS-1:0]  offset;
  } dcache_addr_fields_t;

  // one address word, seen raw or split into its fields
  typedef union packed {
    logic [ADDR_BITS-1:0] raw;
    dcache_addr_fields_t  fields;
  } dcache_addr_t;

endpackage

//--- logic/dcache_data_pkg.sv
// data block width and the value returned on a read miss
package dcache_data_pkg;

  // one cache block
  localparam int WORD_BITS = 64;

  // read data reported when no way hits
  localparam logic [WORD_BITS-1:0] MISS_DATA = '0;

endpackage

//--- logic/dcache_read_result.sv
// read result: hit way encode, block select and registered done, hit and data
`timescale 1ns/1ps

module dcache_read_result
  import dcache_data_pkg::*;
#(
  parameter int NUM_WAYS = 4
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          q_rd1_valid,
  input  logic [NUM_WAYS-1:0]           rd1_hits,
  input  logic [NUM_WAYS*WORD_BITS-1:0] rd1_way_data,
  input  logic                          q_rd2_valid,
  input  logic [NUM_WAYS-1:0]           rd2_hits,
  input  logic [NUM_WAYS*WORD_BITS-1:0] rd2_way_data,
  output logic                          rd1_done,
  output logic                          rd1_hit,
  output logic [WORD_BITS-1:0]          rd1_data,
  output logic                          rd2_done,
  output logic                          rd2_hit,
  output logic [WORD_BITS-1:0]          rd2_data
);

  localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  logic [WAY_BITS-1:0]  rd1_way;
  logic [WAY_BITS-1:0]  rd2_way;
  logic [WORD_BITS-1:0] rd1_sel;
  logic [WORD_BITS-1:0] rd2_sel;

  // lowest hitting way wins
  function automatic logic [WAY_BITS-1:0] hit_index(input logic [NUM_WAYS-1:0] hits);
    logic [WAY_BITS-1:0] index;
    index = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (hits[w]) begin
        index = WAY_BITS'(w);
      end
    end
    return index;
  endfunction

  assign rd1_way = hit_index(rd1_hits);
  assign rd2_way = hit_index(rd2_hits);

  assign rd1_sel = (|rd1_hits) ? rd1_way_data[rd1_way*WORD_BITS +: WORD_BITS] : MISS_DATA;
  assign rd2_sel = (|rd2_hits) ? rd2_way_data[rd2_way*WORD_BITS +: WORD_BITS] : MISS_DATA;

  always_ff @(posedge clock) begin
    if (reset) begin
      rd1_done <= 1'b0;
      rd1_hit  <= 1'b0;
      rd2_done <= 1'b0;
      rd2_hit  <= 1'b0;
    end else begin
      rd1_done <= q_rd1_valid;
      rd1_hit  <= q_rd1_valid && (|rd1_hits);
      rd2_done <= q_rd2_valid;
      rd2_hit  <= q_rd2_valid && (|rd2_hits);
    end
  end

  // data only matters alongside done
  always_ff @(posedge clock) begin
    rd1_data <= rd1_sel;
    rd2_data <= rd2_sel;
  end

  a_rd_hits_onehot: assert property (@(posedge clock) disable iff (reset)
    $onehot0(rd1_hits) && $onehot0(rd2_hits))
    else $error("read hit in more than one way");

endmodule

//--- logic/dcache_request_capture.sv
// request capture: address decode, request registers and same-set write collision drop
`timescale 1ns/1ps

module dcache_request_capture
  import dcache_addr_pkg::*;
  import dcache_data_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  rd1_strobe,
  input  logic [ADDR_BITS-1:0]  rd1_addr,
  input  logic                  rd2_strobe,
  input  logic [ADDR_BITS-1:0]  rd2_addr,
  input  logic                  wr1_strobe,
  input  logic [ADDR_BITS-1:0]  wr1_addr,
  input  logic [WORD_BITS-1:0]  wr1_data,
  input  logic                  wr2_strobe,
  input  logic [ADDR_BITS-1:0]  wr2_addr,
  input  logic [WORD_BITS-1:0]  wr2_data,
  output logic                  q_rd1_valid,
  output logic [SET_BITS-1:0]   q_rd1_set,
  output logic [BLOCK_BITS-1:0] q_rd1_block,
  output logic [TAG_BITS-1:0]   q_rd1_tag,
  output logic                  q_rd2_valid,
  output logic [SET_BITS-1:0]   q_rd2_set,
  output logic [BLOCK_BITS-1:0] q_rd2_block,
  output logic [TAG_BITS-1:0]   q_rd2_tag,
  output logic                  q_wr1_valid,
  output logic [SET_BITS-1:0]   q_wr1_set,
  output logic [BLOCK_BITS-1:0] q_wr1_block,
  output logic [TAG_BITS-1:0]   q_wr1_tag,
  output logic [WORD_BITS-1:0]  q_wr1_data,
  output logic                  q_wr2_valid,
  output logic [SET_BITS-1:0]   q_wr2_set,
  output logic [BLOCK_BITS-1:0] q_wr2_block,
  output logic [TAG_BITS-1:0]   q_wr2_tag,
  output logic [WORD_BITS-1:0]  q_wr2_data,
  output logic                  wr1_drop
);

  dcache_addr_t rd1_view;
  dcache_addr_t rd2_view;
  dcache_addr_t wr1_view;
  dcache_addr_t wr2_view;
  logic         wr_collide;

  always_comb begin
    rd1_view.raw = rd1_addr;
    rd2_view.raw = rd2_addr;
    wr1_view.raw = wr1_addr;
    wr2_view.raw = wr2_addr;
  end

  // both writes into one set, port 2 wins
  assign wr_collide = wr1_strobe && wr2_strobe &&
                      (wr1_view.fields.set == wr2_view.fields.set);

  // strobes and the drop pulse
  always_ff @(posedge clock) begin
    if (reset) begin
      q_rd1_valid <= 1'b0;
      q_rd2_valid <= 1'b0;
      q_wr1_valid <= 1'b0;
      q_wr2_valid <= 1'b0;
      wr1_drop    <= 1'b0;
    end else begin
      q_rd1_valid <= rd1_strobe;
      q_rd2_valid <= rd2_strobe;
      q_wr1_valid <= wr1_strobe && !wr_collide;
      q_wr2_valid <= wr2_strobe;
      wr1_drop    <= wr_collide;
    end
  end

  // address fields and write data
  always_ff @(posedge clock) begin
    q_rd1_set   <= rd1_view.fields.set;
    q_rd1_block <= rd1_view.fields.block;
    q_rd1_tag   <= rd1_view.fields.tag;
    q_rd2_set   <= rd2_view.fields.set;
    q_rd2_block <= rd2_view.fields.block;
    q_rd2_tag   <= rd2_view.fields.tag;
    q_wr1_set   <= wr1_view.fields.set;
    q_wr1_block <= wr1_view.fields.block;
    q_wr1_tag   <= wr1_view.fields.tag;
    q_wr1_data  <= wr1_data;
    q_wr2_set   <= wr2_view.fields.set;
    q_wr2_block <= wr2_view.fields.block;
    q_wr2_tag   <= wr2_view.fields.tag;
    q_wr2_data  <= wr2_data;
  end

  // requests address whole blocks only
  a_block_aligned: assert property (@(posedge clock) disable iff (reset)
    (!rd1_strobe || rd1_view.fields.offset == '0) &&
    (!rd2_strobe || rd2_view.fields.offset == '0) &&
    (!wr1_strobe || wr1_view.fields.offset == '0) &&
    (!wr2_strobe || wr2_view.fields.offset == '0))
    else $error("strobed address with nonzero byte offset");

endmodule

//--- logic/dcache_top.sv
// cache array top level: request capture, way array, victim selection, read result
`timescale 1ns/1ps

module dcache_top
  import dcache_addr_pkg::*;
  import dcache_data_pkg::*;
#(
  parameter int NUM_WAYS = 4
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 rd1_strobe,
  input  logic [ADDR_BITS-1:0] rd1_addr,
  input  logic                 rd2_strobe,
  input  logic [ADDR_BITS-1:0] rd2_addr,
  input  logic                 wr1_strobe,
  input  logic [ADDR_BITS-1:0] wr1_addr,
  input  logic [WORD_BITS-1:0] wr1_data,
  input  logic                 wr2_strobe,
  input  logic [ADDR_BITS-1:0] wr2_addr,
  input  logic [WORD_BITS-1:0] wr2_data,
  output logic                 rd1_done,
  output logic                 rd1_hit,
  output logic [WORD_BITS-1:0] rd1_data,
  output logic                 rd2_done,
  output logic                 rd2_hit,
  output logic [WORD_BITS-1:0] rd2_data,
  output logic                 wr1_drop
);

  logic                          q_rd1_valid, q_rd2_valid, q_wr1_valid, q_wr2_valid;
  logic [SET_BITS-1:0]           q_rd1_set, q_rd2_set, q_wr1_set, q_wr2_set;
  logic [BLOCK_BITS-1:0]         q_rd1_block, q_rd2_block, q_wr1_block, q_wr2_block;
  logic [TAG_BITS-1:0]           q_rd1_tag, q_rd2_tag, q_wr1_tag, q_wr2_tag;
  logic [WORD_BITS-1:0]          q_wr1_data, q_wr2_data;
  logic [NUM_WAYS-1:0]           rd1_hits, rd2_hits, wr1_hits, wr2_hits;
  logic [NUM_WAYS-1:0]           wr1_we, wr2_we;
  logic                          wr1_alloc, wr2_alloc;
  logic [NUM_WAYS*WORD_BITS-1:0] rd1_way_data, rd2_way_data;

  dcache_request_capture u_capture (.*);

  // one way per hit bit, read data packed way by way
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    dcache_way u_way (
      .clock       (clock),       .reset       (reset),
      .q_rd1_valid (q_rd1_valid), .q_rd1_set   (q_rd1_set),
      .q_rd1_block (q_rd1_block), .q_rd1_tag   (q_rd1_tag),
      .q_rd2_valid (q_rd2_valid), .q_rd2_set   (q_rd2_set),
      .q_rd2_block (q_rd2_block), .q_rd2_tag   (q_rd2_tag),
      .q_wr1_valid (q_wr1_valid), .q_wr1_set   (q_wr1_set),
      .q_wr1_block (q_wr1_block), .q_wr1_tag   (q_wr1_tag),
      .q_wr1_data  (q_wr1_data),
      .q_wr2_valid (q_wr2_valid), .q_wr2_set   (q_wr2_set),
      .q_wr2_block (q_wr2_block), .q_wr2_tag   (q_wr2_tag),
      .q_wr2_data  (q_wr2_data),
      .wr1_we      (wr1_we[w]),   .wr2_we      (wr2_we[w]),
      .wr1_alloc   (wr1_alloc),   .wr2_alloc   (wr2_alloc),
      .rd1_hit     (rd1_hits[w]), .rd2_hit     (rd2_hits[w]),
      .wr1_hit     (wr1_hits[w]), .wr2_hit     (wr2_hits[w]),
      .rd1_data    (rd1_way_data[w*WORD_BITS +: WORD_BITS]),
      .rd2_data    (rd2_way_data[w*WORD_BITS +: WORD_BITS])
    );
  end

  dcache_victim_select #(
    .NUM_WAYS (NUM_WAYS)
  ) u_victim (.*);

  dcache_read_result #(
    .NUM_WAYS (NUM_WAYS)
  ) u_result (.*);

endmodule

//--- logic/dcache_victim_select.sv
// victim selection: per-set round-robin pointers, write enables and allocate flags
`timescale 1ns/1ps

module dcache_victim_select
  import dcache_addr_pkg::*;
#(
  parameter int NUM_WAYS = 4
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                q_wr1_valid,
  input  logic [SET_BITS-1:0] q_wr1_set,
  input  logic [NUM_WAYS-1:0] wr1_hits,
  input  logic                q_wr2_valid,
  input  logic [SET_BITS-1:0] q_wr2_set,
  input  logic [NUM_WAYS-1:0] wr2_hits,
  output logic [NUM_WAYS-1:0] wr1_we,
  output logic                wr1_alloc,
  output logic [NUM_WAYS-1:0] wr2_we,
  output logic                wr2_alloc
);

  localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  logic [WAY_BITS-1:0] rr_ptr [NUM_SETS];

  function automatic logic [NUM_WAYS-1:0] way_onehot(input logic [WAY_BITS-1:0] way);
    logic [NUM_WAYS-1:0] result;
    result = '0;
    result[way] = 1'b1;
    return result;
  endfunction

  // wraps at NUM_WAYS, which need not be a power of two
  function automatic logic [WAY_BITS-1:0] advance(input logic [WAY_BITS-1:0] ptr);
    return (ptr == WAY_BITS'(NUM_WAYS - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // a miss allocates the way under the pointer
  assign wr1_alloc = q_wr1_valid && (wr1_hits == '0);
  assign wr2_alloc = q_wr2_valid && (wr2_hits == '0);

  assign wr1_we = wr1_alloc ? way_onehot(rr_ptr[q_wr1_set]) : wr1_hits;
  assign wr2_we = wr2_alloc ? way_onehot(rr_ptr[q_wr2_set]) : wr2_hits;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        rr_ptr[s] <= '0;
      end
    end else begin
      if (wr1_alloc) begin
        rr_ptr[q_wr1_set] <= advance(rr_ptr[q_wr1_set]);
      end
      if (wr2_alloc) begin
        rr_ptr[q_wr2_set] <= advance(rr_ptr[q_wr2_set]);
      end
    end
  end

  // a tag lives in at most one way of a set
  a_wr_hits_onehot: assert property (@(posedge clock) disable iff (reset)
    $onehot0(wr1_hits) && $onehot0(wr2_hits))
    else $error("write hit in more than one way");

endmodule

//--- logic/dcache_way.sv
// one cache way: tag, valid and data storage, hit compare on all ports, write update
`timescale 1ns/1ps

module dcache_way
  import dcache_addr_pkg::*;
  import dcache_data_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  q_rd1_valid,
  input  logic [SET_BITS-1:0]   q_rd1_set,
  input  logic [BLOCK_BITS-1:0] q_rd1_block,
  input  logic [TAG_BITS-1:0]   q_rd1_tag,
  input  logic                  q_rd2_valid,
  input  logic [SET_BITS-1:0]   q_rd2_set,
  input  logic [BLOCK_BITS-1:0] q_rd2_block,
  input  logic [TAG_BITS-1:0]   q_rd2_tag,
  input  logic                  q_wr1_valid,
  input  logic [SET_BITS-1:0]   q_wr1_set,
  input  logic [BLOCK_BITS-1:0] q_wr1_block,
  input  logic [TAG_BITS-1:0]   q_wr1_tag,
  input  logic [WORD_BITS-1:0]  q_wr1_data,
  input  logic                  q_wr2_valid,
  input  logic [SET_BITS-1:0]   q_wr2_set,
  input  logic [BLOCK_BITS-1:0] q_wr2_block,
  input  logic [TAG_BITS-1:0]   q_wr2_tag,
  input  logic [WORD_BITS-1:0]  q_wr2_data,
  input  logic                  wr1_we,
  input  logic                  wr2_we,
  input  logic                  wr1_alloc,
  input  logic                  wr2_alloc,
  output logic                  rd1_hit,
  output logic                  rd2_hit,
  output logic                  wr1_hit,
  output logic                  wr2_hit,
  output logic [WORD_BITS-1:0]  rd1_data,
  output logic [WORD_BITS-1:0]  rd2_data
);

  logic [TAG_BITS-1:0]        tag_mem   [NUM_SETS];
  logic [BLOCKS_PER_LINE-1:0] valid_mem [NUM_SETS];
  logic [WORD_BITS-1:0]       data_mem  [NUM_SETS][BLOCKS_PER_LINE];

  // allocation keeps only the written block valid
  function automatic logic [BLOCKS_PER_LINE-1:0] next_valid(
    input logic [BLOCKS_PER_LINE-1:0] line_valid,
    input logic [BLOCK_BITS-1:0]      block,
    input logic                       alloc
  );
    logic [BLOCKS_PER_LINE-1:0] result;
    result = alloc ? '0 : line_valid;
    result[block] = 1'b1;
    return result;
  endfunction

  // lookup, shared line tag plus per-block valid
  assign rd1_hit = q_rd1_valid && valid_mem[q_rd1_set][q_rd1_block] &&
                   (tag_mem[q_rd1_set] == q_rd1_tag);
  assign rd2_hit = q_rd2_valid && valid_mem[q_rd2_set][q_rd2_block] &&
                   (tag_mem[q_rd2_set] == q_rd2_tag);
  assign wr1_hit = q_wr1_valid && valid_mem[q_wr1_set][q_wr1_block] &&
                   (tag_mem[q_wr1_set] == q_wr1_tag);
  assign wr2_hit = q_wr2_valid && valid_mem[q_wr2_set][q_wr2_block] &&
                   (tag_mem[q_wr2_set] == q_wr2_tag);

  assign rd1_data = data_mem[q_rd1_set][q_rd1_block];
  assign rd2_data = data_mem[q_rd2_set][q_rd2_block];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_mem[s] <= '0;
      end
    end else begin
      if (wr1_we) begin
        valid_mem[q_wr1_set] <= next_valid(valid_mem[q_wr1_set], q_wr1_block, wr1_alloc);
      end
      if (wr2_we) begin
        valid_mem[q_wr2_set] <= next_valid(valid_mem[q_wr2_set], q_wr2_block, wr2_alloc);
      end
    end
  end

  // tags and blocks
  always_ff @(posedge clock) begin
    if (wr1_we) begin
      data_mem[q_wr1_set][q_wr1_block] <= q_wr1_data;
      if (wr1_alloc) begin
        tag_mem[q_wr1_set] <= q_wr1_tag;
      end
    end
    if (wr2_we) begin
      data_mem[q_wr2_set][q_wr2_block] <= q_wr2_data;
      if (wr2_alloc) begin
        tag_mem[q_wr2_set] <= q_wr2_tag;
      end
    end
  end

  // capture drops port 1 on a same-set pair
  a_no_same_set_writes: assert property (@(posedge clock) disable iff (reset)
    !(wr1_we && wr2_we && (q_wr1_set == q_wr2_set)))
    else $error("both write ports enabled for set %0d", q_wr1_set);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the cache array testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f dcache_top.f --top-module dcache_tb

output=$(./obj_dir/Vdcache_tb)
echo "$output"

if grep -q "^Simulation passed$" <<< "$output"; then
  exit 0
fi
exit 1
